// ==== hw/megarom_bank_mapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module megarom_bank_mapper (
   input  wire logic                                clk,
   input  wire logic                                reset,
   input  wire logic [msx_slot_pkg::cpu_addr_w-1:0] cpu_addr,
   input  wire logic [msx_slot_pkg::cpu_data_w-1:0] cpu_dout,
   input  wire logic                                cpu_wr,
   input  wire logic                                cpu_mreq,
   input  wire msx_slot_pkg::mapper_t               mapper,
   input  wire logic                                cart_num,
   input  wire logic [7:0]                          size_pages,
   output logic [msx_slot_pkg::ram_addr_w-1:0]      rom_offset,
   output logic                                     rom_unmapped
);
   import msx_slot_pkg::*;

   // konami bank 0 never changes, banks 1..3 written from 6000-BFFF
   logic [cpu_data_w-1:0] konami_bank [2][4];
   // ascii16 only uses the first two
   logic [cpu_data_w-1:0] ascii_bank [2][4];

   logic                  is_megarom;
   logic                  bank_wr;
   logic [2:0]            addr_8k;
   logic [1:0]            win8;
   logic [ram_addr_w-1:0] raw_offset;
   logic [ram_addr_w-1:0] size_mask;

   assign is_megarom = (mapper == mapper_konami) || (mapper == mapper_ascii8) ||
                       (mapper == mapper_ascii16);
   assign bank_wr    = cpu_mreq && cpu_wr && is_megarom;

   // 8 KB window number, 4000 is window 0
   assign addr_8k = cpu_addr[cpu_addr_w-1 -: 3];
   assign win8    = 2'(addr_8k - 3'd2);

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int c = 0; c < 2; c++) begin
            for (int b = 0; b < 4; b++) begin
               konami_bank[c][b] <= cpu_data_w'(b);
               ascii_bank[c][b]  <= '0;
            end
         end
      end else if (bank_wr) begin
         if (mapper == mapper_konami && addr_8k inside {3'd3, 3'd4, 3'd5}) begin
            konami_bank[cart_num][win8] <= cpu_dout;
         end
         // 6000-7FFF, 2 KB steps select the bank
         if (mapper == mapper_ascii8 && addr_8k == 3'd3) begin
            ascii_bank[cart_num][cpu_addr[12:11]] <= cpu_dout;
         end
         // 6000-67FF and 7000-77FF only
         if (mapper == mapper_ascii16 && addr_8k == 3'd3 && !cpu_addr[11]) begin
            ascii_bank[cart_num][{1'b0, cpu_addr[12]}] <= cpu_dout;
         end
      end
   end

   always_comb begin
      case (mapper)
         mapper_konami: begin
            raw_offset = ram_addr_w'({konami_bank[cart_num][win8], cpu_addr[bank8_w-1:0]});
         end
         mapper_ascii8: begin
            raw_offset = ram_addr_w'({ascii_bank[cart_num][win8], cpu_addr[bank8_w-1:0]});
         end
         mapper_ascii16: begin
            // 4000-7FFF on bank 0, 8000-BFFF on bank 1
            raw_offset = ram_addr_w'({ascii_bank[cart_num][{1'b0, cpu_addr[15]}],
                                      cpu_addr[page_w-1:0]});
         end
         default: begin
            raw_offset = '0;
         end
      endcase
   end

   // rom size in bytes minus one, so banks wrap around
   assign size_mask  = (ram_addr_w'(size_pages) << page_w) - ram_addr_w'(1);
   assign rom_offset = raw_offset & size_mask;

   // pages 0 and 3 are outside the cartridge window
   assign rom_unmapped = is_megarom && (cpu_addr[15] == cpu_addr[14]);

endmodule

`default_nettype wire

// ==== hw/msx_slot_pkg.sv ====
`default_nettype none

package msx_slot_pkg;

   // cpu bus
   localparam int cpu_addr_w = 16;
   localparam int cpu_data_w = 8;

   // external memory, byte address
   localparam int ram_addr_w = 27;

   // address bits inside a 16 KB page
   localparam int page_w = 14;
   // address bits inside an 8 KB megarom window
   localparam int bank8_w = 13;

   // layout indexed by {slot, subslot, page}
   localparam int layout_entries = 64;
   localparam int region_entries = 16;

   // sub-slot select register
   localparam logic [cpu_addr_w-1:0] expander_addr = 16'hffff;

   // configuration port targets
   localparam logic cfg_sel_layout = 1'b0;
   localparam logic cfg_sel_region = 1'b1;

   typedef enum logic [2:0] {
      mapper_unused  = 3'd0,
      mapper_none    = 3'd1,
      mapper_linear  = 3'd2,
      mapper_konami  = 3'd3,
      mapper_ascii8  = 3'd4,
      mapper_ascii16 = 3'd5
   } mapper_t;

   // one entry per slot, subslot and page
   typedef struct packed {
      logic [$clog2(region_entries)-1:0] region;
      logic [1:0]                        page_offset;
      logic                              cart_num;
      mapper_t                           mapper;
   } layout_entry_t;

   // base and size in 16 KB pages
   typedef struct packed {
      logic                           ro;
      logic [7:0]                     size_pages;
      logic [ram_addr_w-page_w-1:0]   base_page;
   } region_entry_t;

   // wide enough for either table entry
   typedef logic [$bits(region_entry_t)-1:0] cfg_data_t;

endpackage

`default_nettype wire

// ==== hw/msx_slots.sv ====
`timescale 1ns/1ps
`default_nettype none

module msx_slots (
   input  wire logic                                              clk,
   input  wire logic                                              reset,
   input  wire logic [msx_slot_pkg::cpu_addr_w-1:0]               cpu_addr,
   input  wire logic [msx_slot_pkg::cpu_data_w-1:0]               cpu_dout,
   output logic [msx_slot_pkg::cpu_data_w-1:0]                    cpu_din,
   input  wire logic                                              cpu_rd,
   input  wire logic                                              cpu_wr,
   input  wire logic                                              cpu_mreq,
   input  wire logic [1:0]                                        active_slot,
   input  wire logic [3:0]                                        expander_en,
   input  wire logic                                              cfg_we,
   input  wire logic                                              cfg_sel,
   input  wire logic [$clog2(msx_slot_pkg::layout_entries)-1:0]   cfg_index,
   input  wire msx_slot_pkg::cfg_data_t                           cfg_data,
   output logic [msx_slot_pkg::ram_addr_w-1:0]                    ram_addr,
   output logic [msx_slot_pkg::cpu_data_w-1:0]                    ram_din,
   input  wire logic [msx_slot_pkg::cpu_data_w-1:0]               ram_dout,
   output logic                                                   ram_rnw,
   output logic                                                   ram_ce
);
   import msx_slot_pkg::*;

   logic [1:0]                   subslot;
   logic                         expander_hit;
   logic [cpu_data_w-1:0]        expander_dout;
   mapper_t                      mapper;
   logic                         cart_num;
   logic [1:0]                   page_offset;
   logic [ram_addr_w-page_w-1:0] base_page;
   logic [7:0]                   size_pages;
   logic                         ro;
   logic [ram_addr_w-1:0]        rom_offset;
   logic                         rom_unmapped;

   subslot_expander u_expander (
      .clk, .reset, .cpu_addr, .cpu_dout, .cpu_rd, .cpu_wr, .cpu_mreq,
      .active_slot, .expander_en, .subslot, .expander_hit, .expander_dout
   );

   slot_layout_table u_layout (
      .clk, .reset, .cfg_we, .cfg_sel, .cfg_index, .cfg_data, .active_slot, .subslot,
      .page(cpu_addr[cpu_addr_w-1 -: 2]),
      .mapper, .cart_num, .page_offset, .base_page, .size_pages, .ro
   );

   megarom_bank_mapper u_banks (
      .clk, .reset, .cpu_addr, .cpu_dout, .cpu_wr, .cpu_mreq, .mapper, .cart_num,
      .size_pages, .rom_offset, .rom_unmapped
   );

   slot_memory_port u_mem_port (
      .cpu_addr, .cpu_dout, .cpu_rd, .cpu_wr, .cpu_mreq, .mapper, .page_offset,
      .base_page, .size_pages, .ro, .rom_offset, .rom_unmapped, .expander_hit,
      .expander_dout, .ram_dout, .ram_addr, .ram_din, .ram_rnw, .ram_ce, .cpu_din
   );

endmodule

`default_nettype wire

// ==== hw/slot_layout_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_layout_table (
   input  wire logic                                              clk,
   input  wire logic                                              reset,
   input  wire logic                                              cfg_we,
   input  wire logic                                              cfg_sel,
   input  wire logic [$clog2(msx_slot_pkg::layout_entries)-1:0]   cfg_index,
   input  wire msx_slot_pkg::cfg_data_t                           cfg_data,
   input  wire logic [1:0]                                        active_slot,
   input  wire logic [1:0]                                        subslot,
   input  wire logic [1:0]                                        page,
   output msx_slot_pkg::mapper_t                                  mapper,
   output logic                                                   cart_num,
   output logic [1:0]                                             page_offset,
   output logic [msx_slot_pkg::ram_addr_w-msx_slot_pkg::page_w-1:0] base_page,
   output logic [7:0]                                             size_pages,
   output logic                                                   ro
);
   import msx_slot_pkg::*;

   localparam int layout_idx_w = $clog2(layout_entries);
   localparam int region_idx_w = $clog2(region_entries);

   layout_entry_t layout_tbl [layout_entries];
   region_entry_t region_tbl [region_entries];

   logic [layout_idx_w-1:0] layout_idx;
   layout_entry_t           cur_layout;
   region_entry_t           cur_region;

   // configuration writes, one entry per edge
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < layout_entries; i++) begin
            layout_tbl[i] <= '0;
         end
         for (int j = 0; j < region_entries; j++) begin
            region_tbl[j] <= '0;
         end
      end else if (cfg_we) begin
         if (cfg_sel == cfg_sel_layout) begin
            layout_tbl[cfg_index] <= layout_entry_t'(cfg_data[$bits(layout_entry_t)-1:0]);
         end
         if (cfg_sel == cfg_sel_region) begin
            region_tbl[cfg_index[region_idx_w-1:0]] <= region_entry_t'(cfg_data);
         end
      end
   end

   // slot, subslot, page picks the layout entry
   assign layout_idx = {active_slot, subslot, page};
   assign cur_layout = layout_tbl[layout_idx];

   // layout entry then points at its ram region
   assign cur_region = region_tbl[cur_layout.region];

   assign mapper      = cur_layout.mapper;
   assign cart_num    = cur_layout.cart_num;
   assign page_offset = cur_layout.page_offset;
   assign base_page   = cur_region.base_page;
   assign size_pages  = cur_region.size_pages;
   assign ro          = cur_region.ro;

endmodule

`default_nettype wire

// ==== hw/slot_memory_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_memory_port (
   input  wire logic [msx_slot_pkg::cpu_addr_w-1:0]                 cpu_addr,
   input  wire logic [msx_slot_pkg::cpu_data_w-1:0]                 cpu_dout,
   input  wire logic                                                cpu_rd,
   input  wire logic                                                cpu_wr,
   input  wire logic                                                cpu_mreq,
   input  wire msx_slot_pkg::mapper_t                               mapper,
   input  wire logic [1:0]                                          page_offset,
   input  wire logic [msx_slot_pkg::ram_addr_w-msx_slot_pkg::page_w-1:0] base_page,
   input  wire logic [7:0]                                          size_pages,
   input  wire logic                                                ro,
   input  wire logic [msx_slot_pkg::ram_addr_w-1:0]                 rom_offset,
   input  wire logic                                                rom_unmapped,
   input  wire logic                                                expander_hit,
   input  wire logic [msx_slot_pkg::cpu_data_w-1:0]                 expander_dout,
   input  wire logic [msx_slot_pkg::cpu_data_w-1:0]                 ram_dout,
   output logic [msx_slot_pkg::ram_addr_w-1:0]                      ram_addr,
   output logic [msx_slot_pkg::cpu_data_w-1:0]                      ram_din,
   output logic                                                     ram_rnw,
   output logic                                                     ram_ce,
   output logic [msx_slot_pkg::cpu_data_w-1:0]                      cpu_din
);
   import msx_slot_pkg::*;

   logic [ram_addr_w-1:0] none_offset;
   logic [ram_addr_w-1:0] linear_offset;
   logic [ram_addr_w-1:0] size_mask;
   logic [ram_addr_w-1:0] offset;
   logic                  unmapped;

   // plain rom/ram, page offset shifts the start
   assign none_offset = ram_addr_w'(cpu_addr[page_w-1:0]) +
                        (ram_addr_w'(page_offset) << page_w);

   assign size_mask     = (ram_addr_w'(size_pages) << page_w) - ram_addr_w'(1);
   assign linear_offset = ram_addr_w'(cpu_addr) & size_mask;

   always_comb begin
      case (mapper)
         mapper_none:   offset = none_offset;
         mapper_linear: offset = linear_offset;
         mapper_konami, mapper_ascii8, mapper_ascii16: offset = rom_offset;
         default:       offset = '0;
      endcase
   end

   assign ram_addr = (ram_addr_w'(base_page) << page_w) + offset;

   // expander register shadows memory at FFFF
   assign unmapped = (mapper == mapper_unused) || rom_unmapped || expander_hit;

   assign ram_ce  = !unmapped && cpu_mreq && (cpu_rd || (cpu_wr && !ro));
   assign ram_rnw = cpu_rd;
   assign ram_din = cpu_dout;

   // idle sources drive all ones so they AND cleanly
   assign cpu_din = expander_dout & (unmapped ? {cpu_data_w{1'b1}} : ram_dout);

endmodule

`default_nettype wire

// ==== hw/subslot_expander.sv ====
`timescale 1ns/1ps
`default_nettype none

module subslot_expander (
   input  wire logic                                clk,
   input  wire logic                                reset,
   input  wire logic [msx_slot_pkg::cpu_addr_w-1:0] cpu_addr,
   input  wire logic [msx_slot_pkg::cpu_data_w-1:0] cpu_dout,
   input  wire logic                                cpu_rd,
   input  wire logic                                cpu_wr,
   input  wire logic                                cpu_mreq,
   input  wire logic [1:0]                          active_slot,
   input  wire logic [3:0]                          expander_en,
   output logic [1:0]                               subslot,
   output logic                                     expander_hit,
   output logic [msx_slot_pkg::cpu_data_w-1:0]      expander_dout
);
   import msx_slot_pkg::*;

   // one select register per primary slot, two bits per page
   logic [cpu_data_w-1:0] sub_reg [4];
   logic [cpu_data_w-1:0] active_reg;
   logic [1:0]            page;

   assign page       = cpu_addr[cpu_addr_w-1 -: 2];
   assign active_reg = sub_reg[active_slot];

   assign expander_hit = cpu_mreq && (cpu_addr == expander_addr) && expander_en[active_slot];

   // register reads back inverted
   assign expander_dout = (expander_hit && cpu_rd) ? ~active_reg : '1;

   // plain slot always sits on sub-slot 0
   assign subslot = expander_en[active_slot] ? active_reg[{page, 1'b0} +: 2] : 2'd0;

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 4; i++) begin
            sub_reg[i] <= '0;
         end
      end else if (expander_hit && cpu_wr) begin
         sub_reg[active_slot] <= cpu_dout;
      end
   end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_msx_slots -Mdir obj_dir -f sim.f \
   || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/Vtb_msx_slots)
echo "$out"
echo "$out" | grep -qx "TEST PASS" && exit 0 || { echo "simulation failed"; exit 1; }

// ==== sim.f ====
+incdir+include
hw/msx_slot_pkg.sv
hw/subslot_expander.sv
hw/slot_layout_table.sv
hw/megarom_bank_mapper.sv
hw/slot_memory_port.sv
hw/msx_slots.sv
tests/tb_msx_slots.sv

// ==== include/tb_slot_model.svh ====
`ifndef TB_SLOT_MODEL_SVH
`define TB_SLOT_MODEL_SVH

// layout word {region, page_offset, cart, mapper}, region word {ro, size, base}
logic [9:0]  m_layout [64];
logic [21:0] m_regions [16];
logic [7:0]  m_sub [4];
logic [7:0]  m_konami [2][4];
logic [7:0]  m_ascii [2][4];

function automatic void reset_model();
   for (int i = 0; i < 64; i++) begin
      m_layout[i] = '0;
   end
   for (int i = 0; i < 16; i++) begin
      m_regions[i] = '0;
   end
   for (int c = 0; c < 2; c++) begin
      for (int b = 0; b < 4; b++) begin
         m_konami[c][b] = 8'(b);
         m_ascii[c][b]  = '0;
      end
   end
   for (int s = 0; s < 4; s++) begin
      m_sub[s] = '0;
   end
endfunction

function automatic void store_cfg_word(input logic sel, input logic [5:0] idx,
                                       input logic [21:0] data);
   if (sel == cfg_sel_layout)
      m_layout[idx] = data[9:0];
   else
      m_regions[idx[3:0]] = data;
endfunction

function automatic logic is_megarom(input logic [2:0] m);
   return m == mapper_konami || m == mapper_ascii8 || m == mapper_ascii16;
endfunction

// {slot, subslot, page}, subslot 0 when the slot has no expander
function automatic int layout_index(input logic [15:0] addr, input logic [1:0] slot,
                                    input logic [3:0] en);
   logic [7:0] shifted;
   logic [1:0] sub;
   shifted = m_sub[slot] >> (2 * addr[15:14]);
   sub     = en[slot] ? shifted[1:0] : 2'd0;
   return int'({slot, sub, addr[15:14]});
endfunction

function automatic void track_bus_write(input logic [15:0] addr, input logic [7:0] dout,
                                        input logic wr, input logic mreq,
                                        input logic [1:0] slot, input logic [3:0] en);
   int         c;
   logic [2:0] m;
   c = int'(m_layout[layout_index(addr, slot, en)][3]);
   m = m_layout[layout_index(addr, slot, en)][2:0];
   if (mreq && wr) begin
      if (m == mapper_konami && addr >= 16'h6000 && addr < 16'hc000)
         m_konami[c][int'((addr - 16'h4000) >> 13)] = dout;
      // 2 KB steps inside 6000-7FFF
      if (m == mapper_ascii8 && addr >= 16'h6000 && addr < 16'h8000)
         m_ascii[c][int'((addr - 16'h6000) >> 11)] = dout;
      if (m == mapper_ascii16 && addr >= 16'h6000 && addr < 16'h6800)
         m_ascii[c][0] = dout;
      if (m == mapper_ascii16 && addr >= 16'h7000 && addr < 16'h7800)
         m_ascii[c][1] = dout;
      // select register last, the bank lookup used the old subslot
      if (addr == 16'hffff && en[slot])
         m_sub[slot] = dout;
   end
endfunction

task automatic predict_outputs(input logic [15:0] addr, input logic rd, input logic wr,
                               input logic mreq, input logic [1:0] slot,
                               input logic [3:0] en, output logic exp_ce,
                               output logic [26:0] exp_addr, output logic [7:0] exp_din);
   logic [9:0]  lay;
   logic [21:0] reg_word;
   int          c;
   int          win;
   logic        hit;
   logic        unmapped;
   logic [26:0] mask;
   logic [26:0] offset;
   lay      = m_layout[layout_index(addr, slot, en)];
   reg_word = m_regions[int'(lay[9:6])];
   c        = int'(lay[3]);
   mask     = (27'(reg_word[20:13]) << 14) - 27'd1;
   // 8 KB window counted from 4000
   win = (addr >= 16'h4000 && addr < 16'hc000) ? int'((addr - 16'h4000) >> 13) : 0;
   case (lay[2:0])
      mapper_none:    offset = 27'(addr[13:0]) + (27'(lay[5:4]) << 14);
      mapper_linear:  offset = 27'(addr) & mask;
      mapper_konami:  offset = ((27'(m_konami[c][win]) << 13) + 27'(addr[12:0])) & mask;
      mapper_ascii8:  offset = ((27'(m_ascii[c][win]) << 13) + 27'(addr[12:0])) & mask;
      mapper_ascii16: offset = ((27'(m_ascii[c][win / 2]) << 14) + 27'(addr[13:0])) & mask;
      default:        offset = '0;
   endcase
   hit      = mreq && addr == 16'hffff && en[slot];
   unmapped = lay[2:0] == mapper_unused || hit ||
              (is_megarom(lay[2:0]) && (addr < 16'h4000 || addr >= 16'hc000));
   exp_addr = (27'(reg_word[12:0]) << 14) + offset;
   exp_ce   = !unmapped && mreq && (rd || (wr && !reg_word[21]));
   exp_din  = ((hit && rd) ? ~m_sub[slot] : 8'hff) &
              (unmapped ? 8'hff : mem_pattern(exp_addr));
endtask

`endif

// ==== tests/tb_msx_slots.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_msx_slots;
   import msx_slot_pkg::*;

   localparam int clk_period = 20;
   localparam int bus_cycles = 2000;
   // reset, 50 idle cycles, 80 table writes and the bus run, plus margin
   localparam int watchdog_cycles = 2500;

   logic        clk = 1'b0;
   logic        reset;
   logic [15:0] cpu_addr;
   logic [7:0]  cpu_dout;
   logic [7:0]  cpu_din;
   logic        cpu_rd;
   logic        cpu_wr;
   logic        cpu_mreq;
   logic [1:0]  active_slot;
   logic [3:0]  expander_en;
   logic        cfg_we;
   logic        cfg_sel;
   logic [5:0]  cfg_index;
   cfg_data_t   cfg_data;
   logic [26:0] ram_addr;
   logic [7:0]  ram_din;
   logic [7:0]  ram_dout;
   logic        ram_rnw;
   logic        ram_ce;
   int          errors = 0;
   int          checks = 0;

   always #(clk_period / 2) clk = ~clk;

   // memory data depends on every address bit
   function automatic logic [7:0] mem_pattern(input logic [26:0] addr);
      return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ {5'b10110, addr[26:24]};
   endfunction

   assign ram_dout = mem_pattern(ram_addr);

   `include "tb_slot_model.svh"

   msx_slots dut (.*);

   task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                  input logic [31:0] got);
      errors++;
      $display("[ERROR] %0t %s expected %0h got %0h", $time, sig, exp, got);
   endtask

   // the model takes the same edge as the DUT, with the inputs held before it
   task automatic apply_edge();
      @(posedge clk);
      if (cfg_we)
         store_cfg_word(cfg_sel, cfg_index, cfg_data);
      track_bus_write(cpu_addr, cpu_dout, cpu_wr, cpu_mreq, active_slot, expander_en);
   endtask

   task automatic check_outputs();
      logic        exp_ce;
      logic [26:0] exp_addr;
      logic [7:0]  exp_din;
      predict_outputs(cpu_addr, cpu_rd, cpu_wr, cpu_mreq, active_slot, expander_en,
                      exp_ce, exp_addr, exp_din);
      checks++;
      if (ram_ce !== exp_ce)
         report_mismatch("ram_ce", 32'(exp_ce), 32'(ram_ce));
      if (exp_ce && ram_addr !== exp_addr)
         report_mismatch("ram_addr", 32'(exp_addr), 32'(ram_addr));
      if (ram_rnw !== cpu_rd)
         report_mismatch("ram_rnw", 32'(cpu_rd), 32'(ram_rnw));
      // write data goes straight through to memory
      if (ram_din !== cpu_dout)
         report_mismatch("ram_din", 32'(cpu_dout), 32'(ram_din));
      if (cpu_din !== exp_din)
         report_mismatch("cpu_din", 32'(exp_din), 32'(cpu_din));
   endtask

   task automatic write_cfg(input logic sel, input logic [5:0] idx, input cfg_data_t data);
      apply_edge();
      cfg_we    <= 1'b1;
      cfg_sel   <= sel;
      cfg_index <= idx;
      cfg_data  <= data;
      cpu_mreq  <= 1'b0;
      @(negedge clk);
      check_outputs();
   endtask

   task automatic random_bus_cycle();
      int pick;
      int op;
      apply_edge();
      pick = $urandom_range(0, 9);
      op   = $urandom_range(0, 7);
      // lean on FFFF and the bank write windows
      if (pick < 3)
         cpu_addr <= 16'hffff;
      else if (pick < 6)
         cpu_addr <= 16'h6000 + 16'($urandom_range(0, 16'h1fff));
      else
         cpu_addr <= 16'($urandom);
      cpu_dout    <= 8'($urandom);
      cpu_mreq    <= op != 7;
      cpu_rd      <= op < 4;
      cpu_wr      <= op >= 4 && op < 7;
      active_slot <= 2'($urandom);
      cfg_we      <= 1'b0;
      if ($urandom_range(0, 31) == 0)
         expander_en <= 4'($urandom);
      @(negedge clk);
      check_outputs();
   endtask

   initial begin
      void'($urandom(32'hee51_0b52));
      reset       = 1'b1;
      cpu_addr    = '0;
      cpu_dout    = '0;
      cpu_rd      = 1'b0;
      cpu_wr      = 1'b0;
      cpu_mreq    = 1'b0;
      active_slot = '0;
      expander_en = 4'b1010;
      cfg_we      = 1'b0;
      cfg_sel     = cfg_sel_layout;
      cfg_index   = '0;
      cfg_data    = '0;
      reset_model();
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      // tables still empty, nothing may reach memory
      repeat (50) random_bus_cycle();
      for (int i = 0; i < 64; i++) begin
         write_cfg(cfg_sel_layout, 6'(i), cfg_data_t'({4'($urandom), 2'($urandom),
                   1'($urandom), 3'($urandom_range(0, 5))}));
      end
      for (int i = 0; i < 16; i++) begin
         write_cfg(cfg_sel_region, 6'(i), cfg_data_t'({$urandom_range(0, 3) == 0,
                   8'($urandom), 13'($urandom)}));
      end
      repeat (bus_cycles) random_bus_cycle();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

   initial begin
      #(watchdog_cycles * clk_period);
      $display("watchdog expired after %0d cycles, stimulus did not finish", watchdog_cycles);
      $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire
